// File: design/uart_defs.svh
// frame width, oversample ratio and baud divider defines for the uart
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// data bits in one frame, sent lsb first
`define UART_DATA_W 8

// oversample ticks per bit, the receiver samples at mid-bit
`define UART_OVERSAMPLE 16

// clk cycles per oversample tick
// one bit = 16 * 4 = 64 clk, one frame of 11 bits = 704 clk
`define UART_CLKS_PER_TICK 4

// derived frame bits around the data
`define UART_FRAME_W (`UART_DATA_W + 1)
`define UART_SHIFT_W (`UART_DATA_W + 3)

`endif

// File: design/uart_pkg.sv
// uart package: byte, frame, shift and counter types, receiver state enum
`default_nettype none

`include "uart_defs.svh"

package uart_pkg;

    typedef logic [`UART_DATA_W-1:0]  uart_byte_t;   // one data byte
    typedef logic [`UART_FRAME_W-1:0] uart_frame_t;  // {parity, data}
    typedef logic [`UART_SHIFT_W-1:0] uart_shift_t;  // {stop, parity, data, start}

    typedef logic [$clog2(`UART_OVERSAMPLE)-1:0] uart_os_cnt_t;  // tick within a bit
    typedef logic [$clog2(`UART_DATA_W)-1:0]     uart_bit_cnt_t; // data bit index

    typedef enum logic [2:0] {
        RX_IDLE,    // line high, waiting for a falling edge
        RX_START,   // qualifying the start bit up to mid-bit
        RX_DATA,    // eight data samples
        RX_PARITY,  // parity sample
        RX_STOP     // stop sample
    } rx_state_t;

endpackage

`default_nettype wire

// File: design/uart_baud_gen.sv
// baud timer: oversample tick and bit tick derived from clk
`timescale 1ns/1ns
`default_nettype none

`include "uart_defs.svh"

module uart_baud_gen import uart_pkg::*; #(
    parameter int CLKS_PER_TICK = `UART_CLKS_PER_TICK  // clk per oversample tick
) (
    input  wire  clk,
    input  wire  reset,
    output logic o_os_tick,   // one clk every CLKS_PER_TICK
    output logic o_bit_tick   // one clk every 16 oversample ticks
);

    localparam int DIV_W = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLKS_PER_TICK - 1);
    localparam uart_os_cnt_t     OS_LAST  = uart_os_cnt_t'(`UART_OVERSAMPLE - 1);
    localparam int BIT_CLKS = CLKS_PER_TICK * `UART_OVERSAMPLE;  // clk per bit

    logic [DIV_W-1:0] div_cnt;  // clk divider
    uart_os_cnt_t     os_cnt;   // oversample ticks within the bit

    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt <= '0;
            os_cnt  <= '0;
        end else begin
            div_cnt <= (div_cnt == DIV_LAST) ? '0 : div_cnt + 1'b1;  // free running
            if (o_os_tick) begin
                os_cnt <= (os_cnt == OS_LAST) ? '0 : os_cnt + 1'b1;
            end
        end
    end

    assign o_os_tick  = (div_cnt == DIV_LAST);           // last clk of each divide
    assign o_bit_tick = o_os_tick && (os_cnt == OS_LAST); // last tick of each bit

    // bit ticks repeat once per bit time, both counters wrap together
    a_bit_period: assert property (@(posedge clk) disable iff (reset)
        o_bit_tick |-> ##(BIT_CLKS) o_bit_tick)
        else $error("bit tick period wrong");

endmodule

`default_nettype wire

// File: design/uart_tx_framer.sv
// one-entry transmit buffer with even parity and shifter load strobe
`timescale 1ns/1ns
`default_nettype none

module uart_tx_framer import uart_pkg::*; (
    input  wire         clk,
    input  wire         reset,
    input  wire         i_tx_valid,  // one-cycle write strobe
    input  uart_byte_t  i_tx_data,   // byte to send
    input  wire         i_busy,      // shifter is sending a frame
    output logic        o_load,      // one-cycle load to the shifter
    output uart_frame_t o_frame,     // {parity, data}
    output logic        o_full       // holding register occupied
);

    logic        full;     // entry valid
    uart_frame_t frame_q;  // held byte with its parity
    logic        accept;   // strobe taken into the entry

    // strobes that find the entry full are lost, there is no back-pressure
    assign accept = i_tx_valid && !full;

    // hand over as soon as the shifter goes idle
    assign o_load = full && !i_busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (o_load) begin
            full <= 1'b0;                  // emptied by the load
        end else if (accept) begin
            full <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            frame_q <= {^i_tx_data, i_tx_data};  // even parity, ones count made even
        end
    end

    assign o_frame = frame_q;
    assign o_full  = full;

    // a load makes the shifter busy on the next clk
    a_load_idle: assert property (@(posedge clk) disable iff (reset)
        o_load |=> i_busy)
        else $error("shifter not busy after framer load");

endmodule

`default_nettype wire

// File: design/uart_tx_shifter.sv
// piso transmit shifter: start, data lsb first, parity, stop, with busy
`timescale 1ns/1ns
`default_nettype none

module uart_tx_shifter import uart_pkg::*; (
    input  wire         clk,
    input  wire         reset,
    input  wire         i_bit_tick,  // one clk per bit time
    input  wire         i_load,      // frame load strobe
    input  uart_frame_t i_frame,     // {parity, data}
    output logic        o_busy,      // frame in flight
    output logic        o_txd        // serial line, idles high
);

    localparam int SHIFT_W = $bits(uart_shift_t);

    uart_shift_t shift_q;  // {stop, parity, data, start}, bit 0 goes out next
    logic        load_ok;  // load taken while idle

    assign load_ok = i_load && !o_busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            shift_q <= '1;                                    // all ones, line idle
        end else if (load_ok) begin
            shift_q <= {1'b1, i_frame, 1'b0};                 // stop, frame, start
        end else if (i_bit_tick && o_busy) begin
            shift_q <= {1'b0, shift_q[SHIFT_W-1:1]};          // zeros mark bits sent
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            o_txd <= 1'b1;
        end else if (i_bit_tick && o_busy) begin
            o_txd <= shift_q[0];  // present the next bit for a full bit time
        end
    end

    // all zeros once the stop bit has shifted out, all ones only after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            o_busy <= 1'b0;
        end else begin
            o_busy <= ((shift_q != '0) && !(&shift_q)) || load_ok;
        end
    end

    // idle out of reset
    a_reset_idle: assert property (@(posedge clk)
        reset |=> !o_busy && (&shift_q))
        else $error("shifter not idle after reset");

    // busy only drops once the stop bit is on the line
    a_idle_high: assert property (@(posedge clk) disable iff (reset)
        !o_busy |-> o_txd)
        else $error("line low while shifter idle");

endmodule

`default_nettype wire

// File: design/uart_rx_ctrl.sv
// receive fsm: start bit qualification and mid-bit sample strobes
`timescale 1ns/1ns
`default_nettype none

`include "uart_defs.svh"

module uart_rx_ctrl import uart_pkg::*; (
    input  wire  clk,
    input  wire  reset,
    input  wire  i_os_tick,        // oversample tick
    input  wire  i_rxd_sync,       // synchronized serial line
    output logic o_sample_data,    // take a data bit
    output logic o_sample_parity,  // take the parity bit
    output logic o_sample_stop     // take the stop bit, frame done
);

    localparam uart_os_cnt_t  OS_MID   = uart_os_cnt_t'(`UART_OVERSAMPLE / 2 - 1);
    localparam uart_os_cnt_t  OS_LAST  = uart_os_cnt_t'(`UART_OVERSAMPLE - 1);
    localparam uart_bit_cnt_t BIT_LAST = uart_bit_cnt_t'(`UART_DATA_W - 1);

    rx_state_t     state;
    uart_os_cnt_t  os_cnt;    // ticks since the last sample point
    uart_bit_cnt_t bit_cnt;   // data bit being received
    logic          mid_tick;  // eighth tick after the falling edge
    logic          bit_end;   // sixteenth tick, next mid-bit

    assign mid_tick = i_os_tick && (os_cnt == OS_MID);
    assign bit_end  = i_os_tick && (os_cnt == OS_LAST);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= RX_IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                RX_IDLE: begin
                    bit_cnt <= '0;
                    if (!i_rxd_sync) begin
                        state <= RX_START;        // falling edge seen
                    end
                end
                RX_START: begin
                    if (mid_tick) begin
                        // still low at mid-bit is a real start bit
                        state <= i_rxd_sync ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BIT_LAST) begin
                            state <= RX_PARITY;
                        end
                    end
                end
                RX_PARITY: begin
                    if (bit_end) begin
                        state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        state <= RX_IDLE;         // done at mid stop bit
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // tick counter restarts at the edge and again at the start bit middle
    always_ff @(posedge clk) begin
        if (reset || state == RX_IDLE) begin
            os_cnt <= '0;
        end else if (i_os_tick) begin
            if ((state == RX_START && os_cnt == OS_MID) || os_cnt == OS_LAST) begin
                os_cnt <= '0;
            end else begin
                os_cnt <= os_cnt + 1'b1;
            end
        end
    end

    assign o_sample_data   = (state == RX_DATA)   && bit_end;
    assign o_sample_parity = (state == RX_PARITY) && bit_end;
    assign o_sample_stop   = (state == RX_STOP)   && bit_end;

    // eight data strobes wrap the bit counter before parity is taken
    a_eight_bits: assert property (@(posedge clk) disable iff (reset)
        o_sample_parity |-> bit_cnt == '0)
        else $error("parity strobe after a wrong data bit count");

endmodule

`default_nettype wire

// File: design/uart_rx_shifter.sv
// rx line synchronizer, shift-in register, parity and stop checks
`timescale 1ns/1ns
`default_nettype none

`include "uart_defs.svh"

module uart_rx_shifter import uart_pkg::*; (
    input  wire        clk,
    input  wire        reset,
    input  wire        i_rxd,            // asynchronous serial line
    input  wire        i_sample_data,    // data bit strobe
    input  wire        i_sample_parity,  // parity bit strobe
    input  wire        i_sample_stop,    // stop bit strobe
    output logic       o_rxd_sync,       // synchronized line to the fsm
    output logic       o_rx_valid,       // one clk per received frame
    output uart_byte_t o_rx_data,        // last received byte
    output logic       o_parity_err,     // last frame had bad parity
    output logic       o_frame_err       // last frame had a low stop bit
);

    logic       rxd_meta;    // first synchronizer flop
    uart_byte_t shift_q;     // data bits, lsb arrives first
    logic       parity_acc;  // xor of data bits so far
    logic       parity_bad;  // parity sample disagreed

    // two flops, both idle high so reset does not look like a start bit
    always_ff @(posedge clk) begin
        if (reset) begin
            rxd_meta   <= 1'b1;
            o_rxd_sync <= 1'b1;
        end else begin
            rxd_meta   <= i_rxd;
            o_rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (i_sample_data) begin
            shift_q <= {o_rxd_sync, shift_q[`UART_DATA_W-1:1]};  // shift in at the top
        end
    end

    always_ff @(posedge clk) begin
        if (reset || i_sample_stop) begin
            parity_acc <= 1'b0;                        // fresh for the next frame
            parity_bad <= 1'b0;
        end else if (i_sample_data) begin
            parity_acc <= parity_acc ^ o_rxd_sync;
        end else if (i_sample_parity) begin
            parity_bad <= parity_acc ^ o_rxd_sync;     // even: total must xor to zero
        end
    end

    // results update together and hold until the next stop strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            o_rx_valid   <= 1'b0;
            o_parity_err <= 1'b0;
            o_frame_err  <= 1'b0;
        end else begin
            o_rx_valid <= i_sample_stop;
            if (i_sample_stop) begin
                o_parity_err <= parity_bad;
                o_frame_err  <= !o_rxd_sync;  // stop bit must be high
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_sample_stop) begin
            o_rx_data <= shift_q;
        end
    end

endmodule

`default_nettype wire

// File: design/uart_top.sv
// uart top: baud timer, transmit framer and shifter, receive fsm and shifter
`timescale 1ns/1ns
`default_nettype none

module uart_top import uart_pkg::*; (
    input  wire        clk,
    input  wire        reset,
    input  wire        i_tx_valid,       // write strobe
    input  uart_byte_t i_tx_data,        // byte to send
    input  wire        i_rxd,            // serial in
    output logic       o_txd,            // serial out
    output logic       o_tx_busy,        // frame on the line
    output logic       o_tx_full,        // holding entry occupied
    output logic       o_rx_valid,       // byte received
    output uart_byte_t o_rx_data,        // received byte
    output logic       o_rx_parity_err,  // parity check failed
    output logic       o_rx_frame_err    // stop bit low
);

    logic        os_tick;        // 16x oversample tick
    logic        bit_tick;       // one per bit time
    logic        tx_load;        // framer to shifter
    uart_frame_t tx_frame;       // {parity, data}
    logic        rxd_sync;       // synchronized rx line
    logic        sample_data;
    logic        sample_parity;
    logic        sample_stop;

    uart_baud_gen u_baud (
        .clk        (clk),
        .reset      (reset),
        .o_os_tick  (os_tick),
        .o_bit_tick (bit_tick)
    );

    uart_tx_framer u_tx_framer (
        .clk        (clk),
        .reset      (reset),
        .i_tx_valid (i_tx_valid),
        .i_tx_data  (i_tx_data),
        .i_busy     (o_tx_busy),   // shifter busy feeds back
        .o_load     (tx_load),
        .o_frame    (tx_frame),
        .o_full     (o_tx_full)
    );

    uart_tx_shifter u_tx_shifter (
        .clk        (clk),
        .reset      (reset),
        .i_bit_tick (bit_tick),
        .i_load     (tx_load),
        .i_frame    (tx_frame),
        .o_busy     (o_tx_busy),
        .o_txd      (o_txd)
    );

    uart_rx_ctrl u_rx_ctrl (
        .clk             (clk),
        .reset           (reset),
        .i_os_tick       (os_tick),
        .i_rxd_sync      (rxd_sync),
        .o_sample_data   (sample_data),
        .o_sample_parity (sample_parity),
        .o_sample_stop   (sample_stop)
    );

    uart_rx_shifter u_rx_shifter (
        .clk             (clk),
        .reset           (reset),
        .i_rxd           (i_rxd),
        .i_sample_data   (sample_data),
        .i_sample_parity (sample_parity),
        .i_sample_stop   (sample_stop),
        .o_rxd_sync      (rxd_sync),
        .o_rx_valid      (o_rx_valid),
        .o_rx_data       (o_rx_data),
        .o_parity_err    (o_rx_parity_err),
        .o_frame_err     (o_rx_frame_err)
    );

endmodule

`default_nettype wire

// File: testbench/tb_uart.sv
// uart testbench: reset, loopback, frame format, drop, error injection and glitch tests
`timescale 1ns/1ns
`default_nettype none

`include "uart_defs.svh"

module tb_uart import uart_pkg::*; ();

    localparam int CLK_NS        = 8;
    localparam int BIT_CLKS      = `UART_OVERSAMPLE * `UART_CLKS_PER_TICK;  // 64 clk per bit
    localparam int FRAME_CLKS    = 11 * BIT_CLKS;                          // 704 clk per frame
    localparam int N_LOOP        = 20;
    localparam int STOP_LOW_CLKS = 44;  // low past the mid-bit stop sample, then high again
    localparam int GLITCH_CLKS   = 24;  // 6 oversample ticks, short of mid-bit
    localparam int WATCHDOG_NS   = 35 * FRAME_CLKS * CLK_NS * 2;  // ~30 frames of traffic, 2x margin

    logic       clk = 1'b0;
    logic       reset;
    logic       tx_valid;
    uart_byte_t tx_data;
    logic       rxd_bb;         // bit-banged rx line
    logic       loop_sel;       // 1 loops txd back to rxd
    wire        rxd_line;
    logic       txd;
    logic       tx_busy;
    logic       tx_full;
    logic       rx_valid;
    uart_byte_t rx_data;
    logic       rx_parity_err;
    logic       rx_frame_err;

    uart_byte_t sent_q[$];      // scoreboard, oldest byte first
    uart_byte_t exp_byte;       // head of the scoreboard
    int         pending;        // bytes still expected
    int         rx_count = 0;
    logic       exp_perr;
    logic       exp_ferr;
    logic       idle_chk;       // check strobes for the assertions
    logic       full_chk;
    logic       fmt_chk;
    logic       fmt_bit;        // expected o_txd level at mid-bit
    int         errors = 0;
    int         tests_run = 0;
    int         tests_failed = 0;
    integer     seed;

    always #(CLK_NS / 2) clk = ~clk;

    assign rxd_line = loop_sel ? txd : rxd_bb;

    uart_top DUT (
        .clk             (clk),
        .reset           (reset),
        .i_tx_valid      (tx_valid),
        .i_tx_data       (tx_data),
        .i_rxd           (rxd_line),
        .o_txd           (txd),
        .o_tx_busy       (tx_busy),
        .o_tx_full       (tx_full),
        .o_rx_valid      (rx_valid),
        .o_rx_data       (rx_data),
        .o_rx_parity_err (rx_parity_err),
        .o_rx_frame_err  (rx_frame_err)
    );

    task automatic show_mismatch(input string name, input logic [7:0] exp, input logic [7:0] got);
        $display("mismatch at time %0t: %s expected %h got %h", $time, name, exp, got);
        errors++;
    endtask

    task automatic note_failure(input string msg);
        $display("error at time %0t: %s", $time, msg);
        errors++;
    endtask

    a_idle_txd: assert property (@(posedge clk) idle_chk |-> txd)
        else show_mismatch("o_txd", 8'h01, {7'b0, $sampled(txd)});
    a_idle_flags: assert property (@(posedge clk)
        idle_chk |-> {tx_busy, tx_full, rx_valid, rx_parity_err, rx_frame_err} == 5'b0)
        else show_mismatch("status flags", 8'h00,
            {3'b0, $sampled({tx_busy, tx_full, rx_valid, rx_parity_err, rx_frame_err})});
    a_rx_data: assert property (@(posedge clk) disable iff (reset)
        rx_valid |-> rx_data == exp_byte)
        else show_mismatch("o_rx_data", $sampled(exp_byte), $sampled(rx_data));
    a_rx_perr: assert property (@(posedge clk) disable iff (reset)
        rx_valid |-> rx_parity_err == exp_perr)
        else show_mismatch("o_rx_parity_err", {7'b0, $sampled(exp_perr)},
            {7'b0, $sampled(rx_parity_err)});
    a_rx_ferr: assert property (@(posedge clk) disable iff (reset)
        rx_valid |-> rx_frame_err == exp_ferr)
        else show_mismatch("o_rx_frame_err", {7'b0, $sampled(exp_ferr)},
            {7'b0, $sampled(rx_frame_err)});
    a_rx_sent: assert property (@(posedge clk) disable iff (reset) rx_valid |-> pending != 0)
        else note_failure("o_rx_valid for a byte that was never sent");
    a_tx_full: assert property (@(posedge clk) full_chk |-> tx_full)
        else show_mismatch("o_tx_full", 8'h01, {7'b0, $sampled(tx_full)});
    a_frame_bit: assert property (@(posedge clk) fmt_chk |-> txd == fmt_bit)
        else show_mismatch("o_txd frame bit", {7'b0, $sampled(fmt_bit)}, {7'b0, $sampled(txd)});

    // pop on each received byte, head feeds a_rx_data
    always @(posedge clk) begin
        if (rx_valid) begin
            if (sent_q.size() > 0) begin
                void'(sent_q.pop_front());
            end
            rx_count <= rx_count + 1;
        end
        pending  <= sent_q.size();
        exp_byte <= (sent_q.size() > 0) ? sent_q[0] : 8'h00;
    end

    // {stop, parity, data lsb first, start}, parity makes the ones count even
    function automatic logic [10:0] frame_bits_of(input uart_byte_t b);
        int ones;
        int i;
        ones = 0;
        for (i = 0; i < 8; i++) begin
            ones += int'(b[i]);
        end
        return {1'b1, ones[0], b, 1'b0};
    endfunction

    task automatic send_byte(input uart_byte_t b);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (tx_full && n < 2 * FRAME_CLKS);  // strobes into a full framer are lost
        if (tx_full) begin
            note_failure("framer stayed full");
        end
        tx_valid <= 1'b1;
        tx_data  <= b;
        sent_q.push_back(b);
        @(posedge clk);
        tx_valid <= 1'b0;
    endtask

    task automatic wait_rx(input int target);
        int n;
        int limit;
        n = 0;
        limit = (target - rx_count + 1) * 2 * FRAME_CLKS;
        while (rx_count < target && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (rx_count < target) begin
            note_failure($sformatf("timeout waiting for received byte %0d", target));
        end
    endtask

    task automatic drive_line(input logic v, input int clks);
        rxd_bb <= v;
        repeat (clks) @(posedge clk);
    endtask

    task automatic inject_frame(input uart_byte_t b, input logic bad_par, input logic low_stop);
        logic [10:0] bits;
        int i;
        bits = frame_bits_of(b);
        bits[9] = bits[9] ^ bad_par;   // flipped parity
        for (i = 0; i < 10; i++) begin
            drive_line(bits[i], BIT_CLKS);
        end
        if (low_stop) begin
            drive_line(1'b0, STOP_LOW_CLKS);
        end
        drive_line(1'b1, 2 * BIT_CLKS);  // stop plus idle gap
    endtask

    task automatic check_frame_format(input uart_byte_t b);
        logic [10:0] bits;
        int n;
        int i;
        bits = frame_bits_of(b);
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (txd && n < 2 * BIT_CLKS);  // falling edge of the start bit
        if (txd) begin
            note_failure("no start bit on o_txd");
        end else begin
            repeat (BIT_CLKS / 2 - 1) @(posedge clk);
            for (i = 0; i < 11; i++) begin
                fmt_bit <= bits[i];
                fmt_chk <= 1'b1;
                @(posedge clk);
                fmt_chk <= 1'b0;
                repeat (BIT_CLKS - 1) @(posedge clk);
            end
        end
    endtask

    task automatic close_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail, %0d errors", name, errors - errs_before);
        end
    endtask

    initial begin
        int e;
        int i;
        int base;
        uart_byte_t b;
        seed     = 32'ha90a_f912;
        reset    = 1'b1;
        tx_valid = 1'b0;
        tx_data  = 8'h00;
        rxd_bb   = 1'b1;
        loop_sel = 1'b1;
        exp_perr = 1'b0;
        exp_ferr = 1'b0;
        idle_chk = 1'b0;
        full_chk = 1'b0;
        fmt_chk  = 1'b0;
        fmt_bit  = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        e = errors;                                   // reset state
        @(posedge clk);
        idle_chk <= 1'b1;
        @(posedge clk);
        idle_chk <= 1'b0;
        close_test("reset", e);

        e = errors;                                   // loopback
        for (i = 0; i < N_LOOP; i++) begin
            send_byte(uart_byte_t'($random(seed)));
        end
        wait_rx(N_LOOP);
        close_test("loopback", e);

        e = errors;                                   // frame format on o_txd
        base = rx_count;
        b = uart_byte_t'($random(seed));
        send_byte(b);
        check_frame_format(b);
        wait_rx(base + 1);
        close_test("frame format", e);

        e = errors;                                   // third strobe finds the framer full
        base = rx_count;
        send_byte(uart_byte_t'($random(seed)));
        i = 0;
        do begin
            @(posedge clk);
            i++;
        end while (!tx_busy && i < 2 * BIT_CLKS);
        if (!tx_busy) begin
            note_failure("o_tx_busy did not rise after a load");
        end
        b = uart_byte_t'($random(seed));
        tx_valid <= 1'b1;
        tx_data  <= b;
        sent_q.push_back(b);
        @(posedge clk);
        tx_data  <= uart_byte_t'($random(seed));  // dropped
        full_chk <= 1'b1;
        @(posedge clk);
        tx_valid <= 1'b0;
        full_chk <= 1'b0;
        wait_rx(base + 2);
        repeat (FRAME_CLKS) @(posedge clk);         // a third byte would land here
        close_test("drop when full", e);

        e = errors;                                   // injected parity and stop errors
        base = rx_count;
        loop_sel <= 1'b0;
        b = uart_byte_t'($random(seed));
        exp_perr = 1'b1;
        sent_q.push_back(b);
        inject_frame(b, 1'b1, 1'b0);
        wait_rx(base + 1);
        exp_perr = 1'b0;
        exp_ferr = 1'b1;
        b = uart_byte_t'($random(seed));
        sent_q.push_back(b);
        inject_frame(b, 1'b0, 1'b1);
        wait_rx(base + 2);
        exp_ferr = 1'b0;
        close_test("error injection", e);

        e = errors;                                   // short low glitch on an idle line
        base = rx_count;
        drive_line(1'b0, GLITCH_CLKS);
        drive_line(1'b1, FRAME_CLKS);
        a_no_rx: assert (rx_count == base)
            else note_failure("glitch was received as a byte");
        close_test("glitch", e);

        a_sb_empty: assert (sent_q.size() == 0)
            else note_failure("bytes sent but never received");
        $display("tests %0d, failed %0d, errors %0d, bytes received %0d",
            tests_run, tests_failed, errors, rx_count);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+design
design/uart_pkg.sv
design/uart_baud_gen.sv
design/uart_tx_framer.sv
design/uart_tx_shifter.sv
design/uart_rx_ctrl.sv
design/uart_rx_shifter.sv
design/uart_top.sv
testbench/tb_uart.sv

// File: run.sh
#!/bin/sh
# build the uart testbench with verilator, run it, pass only if the log has the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --timescale 1ns/1ns --top-module tb_uart \
    -f all.f -o tb_uart &&
./obj_dir/tb_uart | tee sim.log
grep -qx "TEST OK" sim.log || exit 1
